//--- logic/customInstr_macros.svh
`ifndef CUSTOMINSTR_MACROS_SVH
`define CUSTOMINSTR_MACROS_SVH

// Operand and result width of the custom-instruction port.
`define CI_DATA_WIDTH 32
`define CI_ID_WIDTH 8

// Custom-instruction numbers handled by this block.
`define CI_SWAP_ID 1
`define CI_DELAY_ID 6
`define CI_GRAY_ID 9

// The top bit of the reset counter releases the core.
`define RESET_COUNT_WIDTH 5

// System clock cycles per delay unit.
`define DELAY_TICK_CYCLES 4

`endif

//--- logic/customInstrPkg.sv
`default_nettype none

`include "customInstr_macros.svh"

package customInstrPkg;

  typedef enum logic [`CI_ID_WIDTH-1:0] {
    CI_SWAP  = `CI_ID_WIDTH'(`CI_SWAP_ID),
    CI_DELAY = `CI_ID_WIDTH'(`CI_DELAY_ID),
    CI_GRAY  = `CI_ID_WIDTH'(`CI_GRAY_ID)
  } ciOpcode_t;

  // Execution unit picked by the decoder.
  typedef enum logic [1:0] {
    UNIT_NONE,
    UNIT_SWAP,
    UNIT_GRAY,
    UNIT_DELAY
  } ciUnit_t;

  typedef enum logic {
    DELAY_IDLE,
    DELAY_COUNTING
  } delayState_t;

  typedef struct packed {
    logic                      start;
    ciOpcode_t                 opcode;
    logic [`CI_DATA_WIDTH-1:0] dataA;
    logic [`CI_DATA_WIDTH-1:0] dataB;
  } ciRequest_t;

  typedef struct packed {
    logic                      valid;
    ciUnit_t                   unit;
    logic [`CI_DATA_WIDTH-1:0] dataA;
    logic [`CI_DATA_WIDTH-1:0] dataB;
  } ciDispatch_t;

  typedef struct packed {
    logic                      done;
    logic [`CI_DATA_WIDTH-1:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire

//--- logic/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReady
);

  logic [`RESET_COUNT_WIDTH-1:0] resetCount;

  // Counting starts once the PLL has locked and freezes at the top bit.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_WIDTH-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coreReady = resetCount[`RESET_COUNT_WIDTH-1]; // Set after 16 cycles.

endmodule

`default_nettype wire

//--- logic/ciDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module ciDecode (
  input  logic                        s_systemClock,
  input  logic                        s_pllLocked,
  input  logic                        coreReady,
  input  customInstrPkg::ciRequest_t  request,
  output customInstrPkg::ciDispatch_t dispatch
);

  customInstrPkg::ciUnit_t   unitSel;
  customInstrPkg::ciUnit_t   unitReg;
  logic                      validReg;
  logic [`CI_DATA_WIDTH-1:0] dataAReg;
  logic [`CI_DATA_WIDTH-1:0] dataBReg;
  logic                      accept;

  assign accept = request.start && coreReady;

  always_comb begin
    case (request.opcode)
      customInstrPkg::CI_SWAP:  unitSel = customInstrPkg::UNIT_SWAP;
      customInstrPkg::CI_GRAY:  unitSel = customInstrPkg::UNIT_GRAY;
      customInstrPkg::CI_DELAY: unitSel = customInstrPkg::UNIT_DELAY;
      default:                  unitSel = customInstrPkg::UNIT_NONE; // Never acknowledged.
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      validReg <= 1'b0;
      unitReg  <= customInstrPkg::UNIT_NONE;
    end else if (!coreReady) begin
      validReg <= 1'b0; // Held while the core is in reset.
      unitReg  <= customInstrPkg::UNIT_NONE;
    end else begin
      validReg <= accept && (unitSel != customInstrPkg::UNIT_NONE);
      if (accept) unitReg <= unitSel;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      dataAReg <= request.dataA;
      dataBReg <= request.dataB;
    end
  end

  assign dispatch = '{valid: validReg, unit: unitReg, dataA: dataAReg, dataB: dataBReg};

endmodule

`default_nettype wire

//--- logic/ciDelayUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module ciDelayUnit (
  input  logic                      s_systemClock,
  input  logic                      s_pllLocked,
  input  logic                      coreReady,
  input  logic                      beginDelay,
  input  logic [`CI_DATA_WIDTH-1:0] ticks,
  output logic                      done
);

  localparam int COUNT_WIDTH = `CI_DATA_WIDTH + $clog2(`DELAY_TICK_CYCLES) + 1;

  customInstrPkg::delayState_t state;
  logic [COUNT_WIDTH-1:0]      count;
  logic [COUNT_WIDTH-1:0]      loadValue;
  logic                        zeroDelay;

  assign loadValue = COUNT_WIDTH'(ticks) * COUNT_WIDTH'(`DELAY_TICK_CYCLES);
  assign zeroDelay = beginDelay && (ticks == '0);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state <= customInstrPkg::DELAY_IDLE;
      count <= '0;
    end else if (!coreReady) begin
      state <= customInstrPkg::DELAY_IDLE;
      count <= '0;
    end else begin
      case (state)
        customInstrPkg::DELAY_IDLE: begin
          if (beginDelay && !zeroDelay) begin
            state <= customInstrPkg::DELAY_COUNTING;
            count <= loadValue;
          end
        end
        customInstrPkg::DELAY_COUNTING: begin
          if (count == COUNT_WIDTH'(1)) state <= customInstrPkg::DELAY_IDLE;
          count <= count - 1'b1;
        end
        default: state <= customInstrPkg::DELAY_IDLE;
      endcase
    end
  end

  // A zero delay finishes in the cycle it is started.
  assign done = zeroDelay ||
                (state == customInstrPkg::DELAY_COUNTING && count == COUNT_WIDTH'(1));

endmodule

`default_nettype wire

//--- logic/ciExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module ciExecute (
  input  logic                        s_systemClock,
  input  logic                        s_pllLocked,
  input  logic                        coreReady,
  input  customInstrPkg::ciDispatch_t dispatch,
  output customInstrPkg::ciResponse_t unitResponse
);

  logic [`CI_DATA_WIDTH-1:0] swapResult;
  logic [`CI_DATA_WIDTH-1:0] grayResult;
  logic [7:0]                red;
  logic [7:0]                green;
  logic [7:0]                blue;
  logic [15:0]               graySum;
  logic                      delayBegin;
  logic                      delayDone;

  assign swapResult = {dispatch.dataA[7:0], dispatch.dataA[15:8],
                       dispatch.dataA[23:16], dispatch.dataA[31:24]};

  // RGB565 channels scaled up to 8 bits.
  assign red   = {dispatch.dataA[15:11], 3'b000};
  assign green = {dispatch.dataA[10:5], 2'b00};
  assign blue  = {dispatch.dataA[4:0], 3'b000};

  // Weights sum to 256, so the total fits in 16 bits.
  assign graySum    = 16'd54 * red + 16'd183 * green + 16'd19 * blue;
  assign grayResult = {{(`CI_DATA_WIDTH-8){1'b0}}, graySum[15:8]};

  assign delayBegin = dispatch.valid && (dispatch.unit == customInstrPkg::UNIT_DELAY);

  ciDelayUnit delayUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReady    (coreReady),
    .beginDelay   (delayBegin),
    .ticks        (dispatch.dataA),
    .done         (delayDone)
  );

  // Only one instruction is outstanding, so at most one unit completes.
  always_comb begin
    unitResponse = '0;
    if (delayDone) begin
      unitResponse.done = 1'b1; // Delay returns zero.
    end else if (dispatch.valid) begin
      case (dispatch.unit)
        customInstrPkg::UNIT_SWAP: begin
          unitResponse.done   = 1'b1;
          unitResponse.result = swapResult;
        end
        customInstrPkg::UNIT_GRAY: begin
          unitResponse.done   = 1'b1;
          unitResponse.result = grayResult;
        end
        default: unitResponse = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/ciResult.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module ciResult (
  input  logic                        s_systemClock,
  input  logic                        s_pllLocked,
  input  logic                        coreReady,
  input  customInstrPkg::ciResponse_t unitResponse,
  output customInstrPkg::ciResponse_t response
);

  logic                      doneReg;
  logic [`CI_DATA_WIDTH-1:0] resultReg;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      doneReg <= 1'b0;
    end else begin
      doneReg <= coreReady && unitResponse.done; // One-cycle pulse.
    end
  end

  always_ff @(posedge s_systemClock) begin
    resultReg <= unitResponse.result;
  end

  // The result bus stays zero outside the done cycle.
  assign response = '{done: doneReg,
                      result: doneReg ? resultReg : {`CI_DATA_WIDTH{1'b0}}};

endmodule

`default_nettype wire

//--- logic/customInstrTop.sv
`timescale 1ns/1ps
`default_nettype none

module customInstrTop (
  input  logic                        s_systemClock,
  input  logic                        s_pllLocked,
  input  customInstrPkg::ciRequest_t  request,
  output customInstrPkg::ciResponse_t response,
  output logic                        coreReady
);

  customInstrPkg::ciDispatch_t dispatch;
  customInstrPkg::ciResponse_t unitResponse;

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReady    (coreReady)
  );

  // Decode, execute and result stages.
  ciDecode decode (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReady    (coreReady),
    .request      (request),
    .dispatch     (dispatch)
  );

  ciExecute execute (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReady    (coreReady),
    .dispatch     (dispatch),
    .unitResponse (unitResponse)
  );

  ciResult result (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReady    (coreReady),
    .unitResponse (unitResponse),
    .response     (response)
  );

endmodule

`default_nettype wire

//--- sim/customInstrTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "customInstr_macros.svh"

module customInstrTb;

  localparam int CLOCK_PERIOD   = 4;
  localparam int DRIVE_DELAY    = 1;
  localparam int ONE_SHOT_LIMIT = 10;
  localparam int UNKNOWN_WAIT   = 40;
  localparam int RANDOM_COUNT   = 20;
  // Worst case of every test added up, with some margin.
  localparam int WATCHDOG_CYCLES = 30 + (2 * RANDOM_COUNT + 5) * (ONE_SHOT_LIMIT + 3) +
                                   4 * (ONE_SHOT_LIMIT + 3) + 4 * 9 + UNKNOWN_WAIT + 100;

  logic                        s_systemClock;
  logic                        s_pllLocked;
  customInstrPkg::ciRequest_t  request;
  customInstrPkg::ciResponse_t response;
  logic                        coreReady;
  logic [`CI_DATA_WIDTH-1:0]   lcgState = 32'hc53622a1;
  int                          errorCount = 0;
  int                          checkCount = 0;
  int                          missingCount = 0;
  int                          donePulses = 0;

  customInstrTop uut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .request      (request),
    .response     (response),
    .coreReady    (coreReady)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge s_systemClock);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // Sampled mid-cycle, away from the clock edge.
  always @(negedge s_systemClock) begin
    if (response.done === 1'b1) begin
      donePulses++;
    end else if (s_pllLocked && response.result !== '0) begin
      errorCount++;
      $display("[ERROR] %0t: result bus not zero outside done: %h", $time, response.result);
    end
  end

  function automatic logic [`CI_DATA_WIDTH-1:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [`CI_DATA_WIDTH-1:0] swapModel(input logic [31:0] value);
    logic [31:0] swapped;
    for (int i = 0; i < 4; i++) swapped[8*i +: 8] = value[8*(3-i) +: 8];
    return swapped;
  endfunction

  function automatic logic [`CI_DATA_WIDTH-1:0] grayModel(input logic [31:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8; // Channels widened to 8 bits.
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return 32'((54 * red + 183 * green + 19 * blue) >> 8);
  endfunction

  task automatic checkResponse(input customInstrPkg::ciResponse_t got,
                               input customInstrPkg::ciResponse_t expected, input string what);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s: got done %0b result %h, expected done %0b result %h",
               $time, what, got.done, got.result, expected.done, expected.result);
    end
  endtask

  task automatic checkLatency(input int got, input int expected, input string what);
    checkCount++;
    if (got != expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s: %0d cycles, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic checkReady(input logic got, input logic expected, input string what);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s: coreReady %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic checkPulses(input int got, input int expected, input string what);
    checkCount++;
    if (got != expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s: %0d done pulses, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic idleCycles(input int count);
    repeat (count) @(posedge s_systemClock);
    #DRIVE_DELAY;
  endtask

  // Pulses start for one cycle and waits for done, up to limit cycles.
  task automatic issue(input logic [7:0] opcode, input logic [31:0] dataA, input int limit,
                       output customInstrPkg::ciResponse_t got, output int latency,
                       output bit seen);
    seen    = 1'b0;
    latency = 0;
    got     = '0;
    request.opcode = customInstrPkg::ciOpcode_t'(opcode);
    request.dataA  = dataA;
    request.dataB  = nextRandom();
    request.start  = 1'b1;
    while (!seen && latency < limit) begin
      @(posedge s_systemClock);
      #DRIVE_DELAY;
      request.start = 1'b0;
      latency++;
      if (response.done === 1'b1) begin
        seen = 1'b1;
        got  = response;
      end
    end
  endtask

  task automatic runAndCheck(input logic [7:0] opcode, input logic [31:0] dataA,
                             input logic [31:0] expResult, input int expLatency,
                             input string what);
    customInstrPkg::ciResponse_t got;
    customInstrPkg::ciResponse_t expected;
    int                          latency;
    bit                          seen;
    issue(opcode, dataA, expLatency + ONE_SHOT_LIMIT, got, latency, seen);
    if (!seen) begin
      missingCount++;
      $display("%s never completed: no done within %0d cycles", what,
               expLatency + ONE_SHOT_LIMIT);
    end else begin
      expected.done   = 1'b1;
      expected.result = expResult;
      checkResponse(got, expected, what);
      checkLatency(latency, expLatency, what);
    end
  endtask

  task automatic testResetSequence();
    int firstReady;
    int baseDone;
    firstReady = 0;
    baseDone   = donePulses;
    checkReady(coreReady, 1'b0, "during reset");
    request.opcode = customInstrPkg::CI_SWAP;
    request.dataA  = nextRandom();
    s_pllLocked    = 1'b1;
    for (int cycle = 1; cycle <= 24; cycle++) begin
      @(posedge s_systemClock);
      #DRIVE_DELAY;
      request.start = (cycle == 2); // Issued while the core is still held.
      if (coreReady && firstReady == 0) firstReady = cycle;
    end
    checkLatency(firstReady, 16, "coreReady after PLL lock");
    checkPulses(donePulses - baseDone, 0, "start before coreReady");
  endtask

  task automatic testByteSwap();
    logic [31:0] value;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      value = nextRandom();
      runAndCheck(customInstrPkg::CI_SWAP, value, swapModel(value), 2, $sformatf("swap %0d", i));
      idleCycles(1);
    end
  endtask

  task automatic testGrayscale();
    logic [31:0] pixel;
    for (int i = 0; i < RANDOM_COUNT + 2; i++) begin
      if (i == RANDOM_COUNT) pixel = '0;
      else if (i == RANDOM_COUNT + 1) pixel = '1;
      else pixel = nextRandom();
      runAndCheck(customInstrPkg::CI_GRAY, pixel, grayModel(pixel), 2, $sformatf("gray %0d", i));
      idleCycles(1);
    end
  endtask

  task automatic testDelay();
    int ticks[3] = '{0, 1, 5};
    foreach (ticks[i]) begin
      runAndCheck(customInstrPkg::CI_DELAY, 32'(ticks[i]), '0, 2 + 4 * ticks[i],
                  $sformatf("delay %0d", ticks[i]));
      idleCycles(1);
    end
  endtask

  task automatic testUnknownOpcode();
    customInstrPkg::ciResponse_t got;
    int                          latency;
    bit                          seen;
    int                          baseDone;
    logic [31:0]                 value;
    baseDone = donePulses;
    issue(8'd12, nextRandom(), UNKNOWN_WAIT, got, latency, seen);
    checkPulses(donePulses - baseDone, 0, "unknown opcode 12");
    value = nextRandom();
    runAndCheck(customInstrPkg::CI_SWAP, value, swapModel(value), 2, "swap after unknown");
    idleCycles(1);
  endtask

  task automatic testBackToBack();
    int          baseDone;
    logic [31:0] swapValue;
    logic [31:0] pixel;
    baseDone  = donePulses;
    swapValue = nextRandom();
    pixel     = nextRandom();
    runAndCheck(customInstrPkg::CI_SWAP, swapValue, swapModel(swapValue), 2, "chained swap");
    runAndCheck(customInstrPkg::CI_DELAY, 32'd3, '0, 14, "chained delay");
    runAndCheck(customInstrPkg::CI_GRAY, pixel, grayModel(pixel), 2, "chained gray");
    idleCycles(4);
    checkPulses(donePulses - baseDone, 3, "chained instructions");
  endtask

  initial begin
    s_pllLocked = 1'b0;
    request     = '0;
    repeat (3) @(posedge s_systemClock);
    #DRIVE_DELAY;
    testResetSequence();
    testByteSwap();
    testGrayscale();
    testDelay();
    testUnknownOpcode();
    testBackToBack();
    $display("Checks: %0d, errors: %0d, missing done: %0d", checkCount, errorCount, missingCount);
    if (errorCount == 0 && missingCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/customInstrPkg.sv
logic/resetSequencer.sv
logic/ciDecode.sv
logic/ciDelayUnit.sv
logic/ciExecute.sv
logic/ciResult.sv
logic/customInstrTop.sv
sim/customInstrTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module customInstrTb -o customInstrSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/customInstrSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
